// ==== include/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// block RAM region. It spans BRAM_WORDS 32-bit words from its base.
`define BRAM_BASE 32'h0000_0000
`define BRAM_WORDS 1024

// core-local interruptor region.
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

// register offsets inside the CLINT region.
// the high half of each 64-bit register sits four bytes above its low half.
`define CLINT_MSIP_OFS 32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS 32'h0000_BFF8

`endif

// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0] strb_t;

  // strobed byte lanes take the new data, the others keep the old word.
  function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
    word_t merged;
    merged = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        merged[8*lane +: 8] = new_word[8*lane +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

// ==== source/map_pkg.sv ====
`default_nettype none

package map_pkg;

  typedef enum logic [1:0] {
    region_bram,
    region_clint,
    region_none
  } region_e;

  typedef enum logic [2:0] {
    reg_msip,
    reg_mtimecmp_lo,
    reg_mtimecmp_hi,
    reg_mtime_lo,
    reg_mtime_hi,
    reg_none
  } clint_reg_e;

endpackage

`default_nettype wire

// ==== source/mem_bus_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface mem_bus_if
  import bus_pkg::*;
();

  // request, held stable by the host until ready.
  logic  valid;
  addr_t addr;
  word_t wdata;
  strb_t wstrb;

  // response, meaningful only while ready is high.
  word_t rdata;
  logic  error;
  logic  ready;

  modport host (
    output valid, addr, wdata, wstrb,
    input  rdata, error, ready
  );

  modport device (
    input  valid, addr, wdata, wstrb,
    output rdata, error, ready
  );

endinterface

`default_nettype wire

// ==== source/bus_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mem_config.svh"

module bus_decoder
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      mem_valid,
  input  addr_t     mem_addr,
  input  word_t     mem_wdata,
  input  strb_t     mem_wstrb,
  output word_t     mem_rdata,
  output logic      mem_error,
  output logic      mem_ready,
  mem_bus_if.host   ram,
  mem_bus_if.host   timer
);

  localparam addr_t bram_span = addr_t'(`BRAM_WORDS * 4);

  region_e region;
  addr_t   base;
  addr_t   offset;
  logic    err_ready;

  // the region check works on the rebased address, so a base of zero needs no lower bound.
  always_comb begin
    region = region_none;
    base = '0;
    if ((mem_addr - `BRAM_BASE) < bram_span) begin
      region = region_bram;
      base = `BRAM_BASE;
    end else if ((mem_addr - `CLINT_BASE) < `CLINT_SIZE) begin
      region = region_clint;
      base = `CLINT_BASE;
    end
  end

  assign offset = mem_addr - base;

  assign ram.valid = mem_valid && (region == region_bram);
  assign ram.addr = offset;
  assign ram.wdata = mem_wdata;
  assign ram.wstrb = mem_wstrb;

  assign timer.valid = mem_valid && (region == region_clint);
  assign timer.addr = offset;
  assign timer.wdata = mem_wdata;
  assign timer.wstrb = mem_wstrb;

  // unmapped accesses get a one-cycle error answer, once per held request.
  always_ff @(posedge clock) begin
    if (reset) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= mem_valid && (region == region_none) && !err_ready;
    end
  end

  always_comb begin
    mem_rdata = '0;
    mem_error = 1'b0;
    mem_ready = 1'b0;
    if (ram.ready) begin
      mem_rdata = ram.rdata;
      mem_error = ram.error;
      mem_ready = 1'b1;
    end else if (timer.ready) begin
      mem_rdata = timer.rdata;
      mem_error = timer.error;
      mem_ready = 1'b1;
    end else if (err_ready) begin
      mem_error = 1'b1;
      mem_ready = 1'b1;
    end
  end

  // only the addressed target may answer.
  single_ready: assert property (@(posedge clock) disable iff (reset)
    $onehot0({ram.ready, timer.ready, err_ready}));

endmodule

`default_nettype wire

// ==== source/block_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mem_config.svh"

module block_ram
  import bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  mem_bus_if.device  bus
);

  localparam int index_bits = $clog2(`BRAM_WORDS);

  word_t                 memory [`BRAM_WORDS];
  logic [index_bits-1:0] index;
  logic                  access;

  assign index = bus.addr[index_bits+1:2];

  // a held request is served once, in the cycle its ready is still low.
  assign access = bus.valid && !bus.ready;
  assign bus.error = 1'b0;

  always_ff @(posedge clock) begin
    if (reset) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      if (bus.wstrb != '0) begin
        memory[index] <= merge_bytes(memory[index], bus.wdata, bus.wstrb);
        bus.rdata <= '0;
      end else begin
        bus.rdata <= memory[index];
      end
    end
  end

  // the decoder must only route rebased addresses that fall inside the array.
  index_in_range: assert property (@(posedge clock) disable iff (reset)
    bus.valid |-> (bus.addr >> 2) < `BRAM_WORDS);

endmodule

`default_nettype wire

// ==== source/clint.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mem_config.svh"

module clint
  import bus_pkg::*;
  import map_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  mem_bus_if.device  bus,
  output logic       msip,
  output logic       mtip
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  clint_reg_e  sel;
  logic        access;
  logic        write;
  word_t       read_value;

  assign access = bus.valid && !bus.ready;
  assign write = access && (bus.wstrb != '0);
  assign bus.error = 1'b0;

  always_comb begin
    case (bus.addr)
      `CLINT_MSIP_OFS:         sel = reg_msip;
      `CLINT_MTIMECMP_OFS:     sel = reg_mtimecmp_lo;
      `CLINT_MTIMECMP_OFS + 4: sel = reg_mtimecmp_hi;
      `CLINT_MTIME_OFS:        sel = reg_mtime_lo;
      `CLINT_MTIME_OFS + 4:    sel = reg_mtime_hi;
      default:                 sel = reg_none;
    endcase
  end

  // unlisted offsets read as zero.
  always_comb begin
    case (sel)
      reg_msip:        read_value = {31'b0, msip};
      reg_mtimecmp_lo: read_value = mtimecmp[31:0];
      reg_mtimecmp_hi: read_value = mtimecmp[63:32];
      reg_mtime_lo:    read_value = mtime[31:0];
      reg_mtime_hi:    read_value = mtime[63:32];
      default:         read_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bus.ready <= 1'b0;
      msip <= 1'b0;
      mtimecmp <= '1;
      mtip <= 1'b0;
    end else begin
      bus.ready <= access;
      mtip <= (mtime >= mtimecmp);
      if (write) begin
        case (sel)
          reg_msip: begin
            if (bus.wstrb[0]) begin
              msip <= bus.wdata[0];
            end
          end
          reg_mtimecmp_lo: mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus.wdata, bus.wstrb);
          reg_mtimecmp_hi: mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus.wdata, bus.wstrb);
          default: ;
        endcase
      end
    end
  end

  // the timer stands still only in a cycle that writes it.
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else if (write && sel == reg_mtime_lo) begin
      mtime[31:0] <= merge_bytes(mtime[31:0], bus.wdata, bus.wstrb);
    end else if (write && sel == reg_mtime_hi) begin
      mtime[63:32] <= merge_bytes(mtime[63:32], bus.wdata, bus.wstrb);
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (access) begin
      bus.rdata <= write ? '0 : read_value;
    end
  end

  // while no register is written, a raised mtip stays high as mtime keeps counting.
  mtip_holds: assert property (@(posedge clock) disable iff (reset)
    mtip && !$past(write) |=> mtip);

endmodule

`default_nettype wire

// ==== source/mem_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_subsystem
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  mem_valid,
  input  addr_t mem_addr,
  input  word_t mem_wdata,
  input  strb_t mem_wstrb,
  output word_t mem_rdata,
  output logic  mem_error,
  output logic  mem_ready,
  output logic  msip,
  output logic  mtip
);

  mem_bus_if ram_bus ();
  mem_bus_if timer_bus ();

  bus_decoder decoder (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_error (mem_error),
    .mem_ready (mem_ready),
    .ram       (ram_bus.host),
    .timer     (timer_bus.host)
  );

  block_ram bram (
    .clock (clock),
    .reset (reset),
    .bus   (ram_bus.device)
  );

  clint timer (
    .clock (clock),
    .reset (reset),
    .bus   (timer_bus.device),
    .msip  (msip),
    .mtip  (mtip)
  );

endmodule

`default_nettype wire

// ==== tests/tb_mem_subsystem.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "mem_config.svh"

module tb_mem_subsystem
  import bus_pkg::*;
  import map_pkg::*;
();

  localparam int reset_cycles = 8;
  localparam int ram_ops = 96;
  localparam int msip_ops = 8;
  localparam int mtime_pairs = 6;
  localparam int unmapped_ops = 32;
  // nine mtimecmp accesses, three edge addresses and one unlisted CLINT offset.
  localparam int txn_count = ram_ops + 2 * msip_ops + 9 + 2 * mtime_pairs + unmapped_ops + 4;
  localparam int watchdog_ns = txn_count * 6 * 4 + reset_cycles * 4;

  logic  clock;
  logic  reset;
  logic  mem_valid;
  addr_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata;
  logic  mem_error;
  logic  mem_ready;
  logic  msip;
  logic  mtip;

  word_t lcg_state = 32'hc613;
  int    checks = 0;
  int    errors = 0;
  int    cycle_count = 0;

  word_t model_ram [`BRAM_WORDS];
  bit    written_flag [`BRAM_WORDS];
  int    written [$];
  logic  model_msip = 1'b0;
  word_t model_cmp_lo;

  mem_subsystem UUT (
    .clock     (clock),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_error (mem_error),
    .mem_ready (mem_ready),
    .msip      (msip),
    .mtip      (mtip)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  // the low state bits of an LCG repeat quickly, so the high half is folded in.
  function automatic word_t next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  function automatic word_t apply_strobes(word_t old_word, word_t new_word, strb_t strb);
    word_t result;
    for (int b = 0; b < 4; b++) begin
      result[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return result;
  endfunction

  function automatic region_e model_region(addr_t addr);
    if (addr - `BRAM_BASE < `BRAM_WORDS * 4) begin
      return region_bram;
    end else if (addr - `CLINT_BASE < `CLINT_SIZE) begin
      return region_clint;
    end
    return region_none;
  endfunction

  function automatic addr_t clint_addr(clint_reg_e sel);
    case (sel)
      reg_msip:        return `CLINT_BASE + `CLINT_MSIP_OFS;
      reg_mtimecmp_lo: return `CLINT_BASE + `CLINT_MTIMECMP_OFS;
      reg_mtimecmp_hi: return `CLINT_BASE + `CLINT_MTIMECMP_OFS + 4;
      reg_mtime_lo:    return `CLINT_BASE + `CLINT_MTIME_OFS;
      reg_mtime_hi:    return `CLINT_BASE + `CLINT_MTIME_OFS + 4;
      default:         return `CLINT_BASE + 32'h100;
    endcase
  endfunction

  task automatic compare_word(word_t actual, word_t expected, string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic compare_bit(logic actual, logic expected, string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // starts and ends on a falling edge; ready must come one cycle after valid.
  task automatic bus_access(addr_t addr, word_t wdata, strb_t wstrb,
                            output word_t rdata, output logic error);
    int waited;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!mem_ready && waited < 4);
    rdata = mem_rdata;
    error = mem_error;
    mem_valid = 1'b0;
    if (!mem_ready) begin
      errors++;
      rdata = '0;
      error = 1'b1;
      $display("request to address %h got no ready within 4 cycles", addr);
    end else begin
      if (waited != 1) begin
        errors++;
        $display("MISMATCH at %0t: ready came %0d cycles after valid, expected 1",
                 $time, waited);
      end
      @(negedge clock);
      compare_bit(mem_ready, 1'b0, "ready pulse lasts one cycle");
    end
  endtask

  task automatic access_ok(addr_t addr, word_t wdata, strb_t wstrb, output word_t rdata);
    logic error;
    bus_access(addr, wdata, wstrb, rdata, error);
    compare_bit(error, 1'b0, $sformatf("error flag for mapped address %h", addr));
    if (wstrb != '0) begin
      compare_word(rdata, '0, $sformatf("read data of write to %h", addr));
    end
  endtask

  task automatic check_unmapped(addr_t addr, word_t wdata, strb_t wstrb);
    word_t rdata;
    logic  error;
    bus_access(addr, wdata, wstrb, rdata, error);
    compare_bit(error, 1'b1, $sformatf("error flag for unmapped address %h", addr));
    compare_word(rdata, '0, $sformatf("read data of unmapped address %h", addr));
  endtask

  initial begin
    word_t data;
    word_t rdata;
    word_t first;
    word_t second;
    addr_t addr;
    strb_t strb;
    int    index;
    int    first_cycle;
    int    second_cycle;
    reset = 1'b1;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    compare_bit(mem_ready, 1'b0, "ready after reset");
    compare_bit(mem_error, 1'b0, "error after reset");
    compare_bit(msip, 1'b0, "msip after reset");
    compare_bit(mtip, 1'b0, "mtip after reset");

    // the first write to a word sets all four bytes, so later reads hold no unknown lanes.
    for (int i = 0; i < ram_ops; i++) begin
      data = next_random();
      if (written.size() == 0 || data[28]) begin
        index = next_random() % `BRAM_WORDS;
        data = next_random();
        strb = written_flag[index] ? strb_t'(next_random() % 15 + 1) : 4'hf;
        access_ok(`BRAM_BASE + index * 4, data, strb, rdata);
        model_ram[index] = apply_strobes(model_ram[index], data, strb);
        if (!written_flag[index]) begin
          written_flag[index] = 1'b1;
          written.push_back(index);
        end
      end else begin
        index = written[next_random() % written.size()];
        access_ok(`BRAM_BASE + index * 4, '0, '0, rdata);
        compare_word(rdata, model_ram[index], $sformatf("ram read of word %0d", index));
      end
    end

    for (int i = 0; i < msip_ops; i++) begin
      data = next_random();
      strb = strb_t'(next_random() % 15 + 1);
      access_ok(clint_addr(reg_msip), data, strb, rdata);
      if (strb[0]) begin
        model_msip = data[0];
      end
      compare_bit(msip, model_msip, "msip output");
      access_ok(clint_addr(reg_msip), '0, '0, rdata);
      compare_word(rdata, {31'b0, model_msip}, "msip read");
    end

    access_ok(clint_addr(reg_mtimecmp_lo), '0, '0, rdata);
    compare_word(rdata, '1, "mtimecmp low half after reset");
    access_ok(clint_addr(reg_mtimecmp_hi), '0, '0, rdata);
    compare_word(rdata, '1, "mtimecmp high half after reset");
    access_ok(clint_addr(reg_mtimecmp_lo), '0, 4'hf, rdata);
    access_ok(clint_addr(reg_mtimecmp_hi), '0, 4'hf, rdata);
    repeat (2) @(negedge clock);
    compare_bit(mtip, 1'b1, "mtip with mtimecmp at zero");
    access_ok(clint_addr(reg_mtimecmp_lo), '0, '0, rdata);
    compare_word(rdata, '0, "mtimecmp low half after clearing");
    // with the high half at all ones the compare lies far beyond mtime.
    access_ok(clint_addr(reg_mtimecmp_hi), '1, 4'hf, rdata);
    data = next_random();
    strb = strb_t'(next_random() % 15 + 1);
    access_ok(clint_addr(reg_mtimecmp_lo), data, strb, rdata);
    model_cmp_lo = apply_strobes('0, data, strb);
    repeat (2) @(negedge clock);
    compare_bit(mtip, 1'b0, "mtip with mtimecmp high half at all ones");
    access_ok(clint_addr(reg_mtimecmp_lo), '0, '0, rdata);
    compare_word(rdata, model_cmp_lo, "mtimecmp low half read back");
    access_ok(clint_addr(reg_mtimecmp_hi), '0, '0, rdata);
    compare_word(rdata, '1, "mtimecmp high half read back");

    for (int i = 0; i < mtime_pairs; i++) begin
      access_ok(clint_addr(reg_mtime_lo), '0, '0, first);
      first_cycle = cycle_count;
      repeat (next_random() % 8) @(negedge clock);
      access_ok(clint_addr(reg_mtime_lo), '0, '0, second);
      second_cycle = cycle_count;
      checks++;
      if (second <= first || second - first > word_t'(second_cycle - first_cycle)) begin
        errors++;
        $display("MISMATCH at %0t: mtime went from %0d to %0d over %0d cycles",
                 $time, first, second, second_cycle - first_cycle);
      end
    end

    for (int i = 0; i < unmapped_ops; i++) begin
      addr = next_random();
      if (model_region(addr) != region_none) begin
        addr = addr | 32'h8000_0000;
      end
      data = next_random();
      check_unmapped(addr, data, strb_t'(next_random() % 16));
    end
    check_unmapped(`BRAM_BASE + `BRAM_WORDS * 4, '0, '0);
    check_unmapped(`CLINT_BASE - 4, '0, '0);
    check_unmapped(`CLINT_BASE + `CLINT_SIZE, '0, '0);
    access_ok(clint_addr(reg_none), '0, '0, rdata);
    compare_word(rdata, '0, "unlisted CLINT offset");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/bus_pkg.sv
source/map_pkg.sv
source/mem_bus_if.sv
source/bus_decoder.sv
source/block_ram.sv
source/clint.sv
source/mem_subsystem.sv
tests/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - include
    files:
      - source/bus_pkg.sv
      - source/map_pkg.sv
      - source/mem_bus_if.sv
      - source/bus_decoder.sv
      - source/block_ram.sv
      - source/clint.sv
      - source/mem_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_mem_subsystem.sv
